/* common/cpu_pkg.sv */
// shared types for the 32-bit core; word access only, no HI/LO, CP0 or jump encodings
package cpu_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI     // passes operand b, already shifted in decode
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     rs_data;   // operand a from the register file
        word_t     rt_data;   // operand b from the register file
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        logic      use_imm;
        logic      reg_write;
        logic      is_beq;
        logic      is_bne;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;     // alu result or memory address
        word_t     store_data;
        reg_addr_t dest;
        mem_op_e   mem_op;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic      wen;
        word_t     pc;
        reg_addr_t dest;
        word_t     data;
    } wb_write_t;

endpackage

/* fetch/fetch_stage.sv */
// fetch with no delay slot; inst_rdata must belong to inst_addr in the same cycle
module fetch_stage (
    input  logic             aclk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             redirect,
    input  cpu_pkg::word_t   branch_target,
    output cpu_pkg::word_t   inst_addr,
    input  cpu_pkg::word_t   inst_rdata,
    output cpu_pkg::if_id_t  if_id
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_next;

    assign inst_addr = pc;

    // redirect wins over a load-use hold
    always_comb begin
        if (redirect) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= cpu_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (redirect) begin
            if_id.valid <= 1'b0;   // wrong-path word dropped
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= inst_rdata;
        end
    end

endmodule

/* decode/reg_file.sv */
// 32 x 32 registers, r0 reads zero; same-cycle writeback is passed straight to the read ports
module reg_file (
    input  logic                aclk,
    input  logic                rst_n,
    input  cpu_pkg::reg_addr_t  rs_addr,
    input  cpu_pkg::reg_addr_t  rt_addr,
    output cpu_pkg::word_t      rs_data,
    output cpu_pkg::word_t      rt_data,
    input  cpu_pkg::wb_write_t  wb
);

    cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

    logic wr_en;

    assign wr_en = wb.wen && (wb.dest != '0);   // r0 never written

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through bypass
    assign rs_data = (wr_en && wb.dest == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_data = (wr_en && wb.dest == rt_addr) ? wb.data : regs[rt_addr];

endmodule

/* decode/decode_stage.sv */
// decodes the integer subset only; any other opcode leaves as a bubble that writes nothing
module decode_stage (
    input  logic                aclk,
    input  logic                rst_n,
    input  cpu_pkg::if_id_t     if_id,
    output cpu_pkg::reg_addr_t  rs_addr,
    output cpu_pkg::reg_addr_t  rt_addr,
    input  cpu_pkg::word_t      rs_data,
    input  cpu_pkg::word_t      rt_data,
    input  logic                flush,
    output logic                stall,
    output cpu_pkg::id_ex_t     id_ex
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    logic [15:0]         imm16;
    cpu_pkg::reg_addr_t  rd;
    logic                legal;
    cpu_pkg::id_ex_t     id_ex_next;

    assign opcode  = if_id.instr[31:26];
    assign rs_addr = if_id.instr[25:21];
    assign rt_addr = if_id.instr[20:16];
    assign rd      = if_id.instr[15:11];
    assign imm16   = if_id.instr[15:0];
    assign funct   = if_id.instr[5:0];

    // load in execute feeding this instruction, one bubble needed
    assign stall = if_id.valid && id_ex.valid
                && (id_ex.mem_op == cpu_pkg::MEM_LOAD) && (id_ex.dest != '0)
                && ((id_ex.dest == rs_addr) || (id_ex.dest == rt_addr));

    always_comb begin
        legal                = 1'b1;
        id_ex_next.pc        = if_id.pc;
        id_ex_next.rs_data   = rs_data;
        id_ex_next.rt_data   = rt_data;
        id_ex_next.rs        = rs_addr;
        id_ex_next.rt        = rt_addr;
        id_ex_next.imm       = {{16{imm16[15]}}, imm16};   // sign-extended by default
        id_ex_next.dest      = rt_addr;
        id_ex_next.alu_op    = cpu_pkg::ALU_ADD;
        id_ex_next.mem_op    = cpu_pkg::MEM_NONE;
        id_ex_next.use_imm   = 1'b1;
        id_ex_next.reg_write = 1'b0;
        id_ex_next.is_beq    = 1'b0;
        id_ex_next.is_bne    = 1'b0;

        case (opcode)
            cpu_pkg::OP_SPECIAL: begin
                id_ex_next.dest      = rd;
                id_ex_next.use_imm   = 1'b0;
                id_ex_next.reg_write = 1'b1;
                case (funct)
                    cpu_pkg::FUNCT_ADDU: id_ex_next.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FUNCT_SUBU: id_ex_next.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FUNCT_AND:  id_ex_next.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FUNCT_OR:   id_ex_next.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FUNCT_XOR:  id_ex_next.alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FUNCT_SLT:  id_ex_next.alu_op = cpu_pkg::ALU_SLT;
                    default:             legal = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                id_ex_next.reg_write = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                id_ex_next.alu_op    = cpu_pkg::ALU_OR;
                id_ex_next.imm       = {16'h0000, imm16};   // zero-extended
                id_ex_next.reg_write = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                id_ex_next.alu_op    = cpu_pkg::ALU_LUI;
                id_ex_next.imm       = {imm16, 16'h0000};
                id_ex_next.reg_write = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                id_ex_next.mem_op    = cpu_pkg::MEM_LOAD;
                id_ex_next.reg_write = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                id_ex_next.mem_op = cpu_pkg::MEM_STORE;
            end
            cpu_pkg::OP_BEQ: begin
                id_ex_next.use_imm = 1'b0;   // compare rs with rt
                id_ex_next.is_beq  = 1'b1;
            end
            cpu_pkg::OP_BNE: begin
                id_ex_next.use_imm = 1'b0;
                id_ex_next.is_bne  = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        id_ex_next.valid = if_id.valid && legal && !stall && !flush;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;   // bubble when valid is low
        end
    end

endmodule

/* execute/execute_stage.sv */
// branches resolve here and flush two younger slots; a load result is never taken from ex_mem
module execute_stage (
    input  logic                aclk,
    input  logic                rst_n,
    input  cpu_pkg::id_ex_t     id_ex,
    input  cpu_pkg::wb_write_t  wb,
    output logic                redirect,
    output cpu_pkg::word_t      branch_target,
    output cpu_pkg::ex_mem_t    ex_mem
);

    cpu_pkg::word_t   op_a;
    cpu_pkg::word_t   op_b_reg;   // forwarded rt, also the store data
    cpu_pkg::word_t   alu_b;
    cpu_pkg::word_t   alu_result;
    cpu_pkg::ex_mem_t ex_mem_next;

    // newest producer first
    function automatic cpu_pkg::word_t forward(
        input cpu_pkg::reg_addr_t  src,
        input cpu_pkg::word_t      reg_value,
        input cpu_pkg::ex_mem_t    mem_src,
        input cpu_pkg::wb_write_t  wb_src
    );
        cpu_pkg::word_t value;
        value = reg_value;
        if (src == '0) begin
            value = reg_value;   // r0 stays zero
        end else if (mem_src.valid && mem_src.reg_write && mem_src.dest == src
                     && mem_src.mem_op != cpu_pkg::MEM_LOAD) begin
            value = mem_src.result;
        end else if (wb_src.wen && wb_src.dest == src) begin
            value = wb_src.data;
        end
        return value;
    endfunction

    assign op_a     = forward(id_ex.rs, id_ex.rs_data, ex_mem, wb);
    assign op_b_reg = forward(id_ex.rt, id_ex.rt_data, ex_mem, wb);
    assign alu_b    = id_ex.use_imm ? id_ex.imm : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::ALU_ADD: alu_result = op_a + alu_b;
            cpu_pkg::ALU_SUB: alu_result = op_a - alu_b;
            cpu_pkg::ALU_AND: alu_result = op_a & alu_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | alu_b;
            cpu_pkg::ALU_XOR: alu_result = op_a ^ alu_b;
            cpu_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
            cpu_pkg::ALU_LUI: alu_result = alu_b;
            default:          alu_result = '0;
        endcase
    end

    // target relative to the following instruction
    assign branch_target = id_ex.pc + 32'd4 + {id_ex.imm[29:0], 2'b00};
    assign redirect      = id_ex.valid
                        && ((id_ex.is_beq && op_a == op_b_reg)
                         || (id_ex.is_bne && op_a != op_b_reg));

    always_comb begin
        ex_mem_next.valid      = id_ex.valid;
        ex_mem_next.pc         = id_ex.pc;
        ex_mem_next.result     = alu_result;
        ex_mem_next.store_data = op_b_reg;
        ex_mem_next.dest       = id_ex.dest;
        ex_mem_next.mem_op     = id_ex.mem_op;
        ex_mem_next.reg_write  = id_ex.valid && id_ex.reg_write && (id_ex.dest != '0);
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_next;
        end
    end

endmodule

/* verilog/mem_wb_stage.sv */
// word-only data access; data_rdata must answer data_addr in the same cycle
module mem_wb_stage (
    input  logic                aclk,
    input  logic                rst_n,
    input  cpu_pkg::ex_mem_t    ex_mem,
    output cpu_pkg::word_t      data_addr,
    output cpu_pkg::word_t      data_wdata,
    output logic                data_wen,
    input  cpu_pkg::word_t      data_rdata,
    output cpu_pkg::wb_write_t  wb
);

    cpu_pkg::wb_write_t wb_next;

    assign data_addr  = ex_mem.result;
    assign data_wdata = ex_mem.store_data;
    assign data_wen   = ex_mem.valid && (ex_mem.mem_op == cpu_pkg::MEM_STORE);   // one pulse per store

    always_comb begin
        wb_next.wen  = ex_mem.valid && ex_mem.reg_write;
        wb_next.pc   = ex_mem.pc;
        wb_next.dest = ex_mem.dest;
        if (ex_mem.mem_op == cpu_pkg::MEM_LOAD) begin
            wb_next.data = data_rdata;
        end else begin
            wb_next.data = ex_mem.result;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

endmodule

/* verilog/mycpu_top.sv */
// five-stage core; instruction and data ports must answer combinationally, no handshake
module mycpu_top (
    input  logic                aclk,
    input  logic                rst_n,
    output cpu_pkg::word_t      inst_addr,
    input  cpu_pkg::word_t      inst_rdata,
    output cpu_pkg::word_t      data_addr,
    output cpu_pkg::word_t      data_wdata,
    output logic                data_wen,
    input  cpu_pkg::word_t      data_rdata,
    output cpu_pkg::word_t      debug_wb_pc,
    output cpu_pkg::word_t      debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t  debug_wb_rf_wnum
);

    cpu_pkg::if_id_t     if_id;
    cpu_pkg::id_ex_t     id_ex;
    cpu_pkg::ex_mem_t    ex_mem;
    cpu_pkg::wb_write_t  wb;         // register write, forwarding and trace

    logic                stall;      // load-use hold from decode
    logic                redirect;   // taken branch from execute
    cpu_pkg::word_t      branch_target;

    cpu_pkg::reg_addr_t  rs_addr;
    cpu_pkg::reg_addr_t  rt_addr;
    cpu_pkg::word_t      rs_data;
    cpu_pkg::word_t      rt_data;

    // golden trace
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wdata = wb.data;
    assign debug_wb_rf_wen   = {4{wb.wen}};
    assign debug_wb_rf_wnum  = wb.dest;

    fetch_stage u_fetch (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .stall         (stall),
        .redirect      (redirect),
        .branch_target (branch_target),
        .inst_addr     (inst_addr),
        .inst_rdata    (inst_rdata),
        .if_id         (if_id)
    );

    decode_stage u_decode (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .if_id   (if_id),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .flush   (redirect),
        .stall   (stall),
        .id_ex   (id_ex)
    );

    reg_file u_reg_file (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    execute_stage u_execute (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .id_ex         (id_ex),
        .wb            (wb),
        .redirect      (redirect),
        .branch_target (branch_target),
        .ex_mem        (ex_mem)
    );

    mem_wb_stage u_mem_wb (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_wen   (data_wen),
        .data_rdata (data_rdata),
        .wb         (wb)
    );

endmodule

/* tests/cpu_properties.sv */
// port-level rules only, no pipeline internals; checked on the rising clock edge
module cpu_properties (
    input  logic                aclk,
    input  logic                rst_n,
    input  cpu_pkg::word_t      inst_addr,
    input  logic                data_wen,
    input  logic [3:0]          debug_wb_rf_wen,
    input  cpu_pkg::reg_addr_t  debug_wb_rf_wnum
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;   // failed assertions so far

    wen_all_or_none: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else begin
            failures++;
            $error("partial trace enable %b", debug_wb_rf_wen);
        end

    // r0 writes are dropped in execute
    no_r0_write: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != '0)
        else begin
            failures++;
            $error("write record names r0");
        end

    fetch_aligned: assert property (@(posedge aclk) disable iff (!rst_n)
        inst_addr[1:0] == 2'b00)
        else begin
            failures++;
            $error("fetch address %h not word aligned", inst_addr);
        end

    quiet_in_reset: assert property (@(posedge aclk)
        !rst_n |-> (data_wen == 1'b0 && debug_wb_rf_wen == 4'h0))
        else begin
            failures++;
            $error("store or write strobe active during reset");
        end

endmodule

/* tests/tb_top.sv */
// program, data and expected writes come from tests/program_input.txt; memories are 1 KB each
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic                aclk;
    logic                rst_n;
    cpu_pkg::word_t      inst_addr;
    cpu_pkg::word_t      inst_rdata;
    cpu_pkg::word_t      data_addr;
    cpu_pkg::word_t      data_wdata;
    logic                data_wen;
    cpu_pkg::word_t      data_rdata;
    cpu_pkg::word_t      debug_wb_pc;
    cpu_pkg::word_t      debug_wb_rf_wdata;
    logic [3:0]          debug_wb_rf_wen;
    cpu_pkg::reg_addr_t  debug_wb_rf_wnum;

    cpu_pkg::word_t imem [256];        // word index from address bits 9:2
    cpu_pkg::word_t dmem [256];
    cpu_pkg::word_t dmem_init [256];   // contents restored while in reset

    cpu_pkg::word_t      exp_pc [$];
    cpu_pkg::reg_addr_t  exp_reg [$];
    cpu_pkg::word_t      exp_data [$];

    int   prog_words = 0;
    int   rec_count = 0;
    logic loaded = 1'b0;

    mycpu_top dut_i (.*);

    bind mycpu_top cpu_properties props_i (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .inst_addr        (inst_addr),
        .data_wen         (data_wen),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum)
    );

    assign inst_rdata = imem[inst_addr[9:2]];
    assign data_rdata = dmem[data_addr[9:2]];

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input cpu_pkg::word_t actual,
                               input cpu_pkg::word_t expected);
        if (actual !== expected) begin
            $display("Error at %0.1f ns: %s is %h, expected %h", $realtime, what, actual,
                     expected);
            abort_run();
        end
    endtask

    task automatic load_program();
        int                  fd;
        int                  c;
        int                  n;
        logic [7:0]          ch;
        logic                malformed;
        cpu_pkg::word_t      addr;
        cpu_pkg::word_t      value;
        cpu_pkg::reg_addr_t  rnum;
        malformed = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i]      = '0;
            dmem_init[i] = 32'h5a5a_0000 | (i << 2);   // unset words show their address
        end
        fd = $fopen("tests/program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/program_input.txt");
            abort_run();
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = c[7:0];
                if (ch == "#") begin
                    while (c != -1 && c != 10) begin   // skip to end of line
                        c = $fgetc(fd);
                    end
                end else if (ch == "i") begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    if (n != 2) malformed = 1'b1;
                    imem[addr[9:2]] = value;
                    prog_words++;
                end else if (ch == "d") begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    if (n != 2) malformed = 1'b1;
                    dmem_init[addr[9:2]] = value;
                end else if (ch == "e") begin
                    n = $fscanf(fd, "%h %d %h", addr, rnum, value);
                    if (n != 3) malformed = 1'b1;
                    exp_pc.push_back(addr);
                    exp_reg.push_back(rnum);
                    exp_data.push_back(value);
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            if (malformed || exp_pc.size() == 0) begin
                $display("the program file has a malformed line or no expected writes");
                abort_run();
            end
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // data model, write on the edge that ends the store's memory cycle
    always @(posedge aclk) begin
        if (!rst_n) begin
            dmem <= dmem_init;
        end else if (data_wen) begin
            dmem[data_addr[9:2]] <= data_wdata;
        end
    end

    // outputs are registered, so sample away from the active edge
    always @(negedge aclk) begin
        if (dut_i.props_i.failures != 0) begin
            $display("a port assertion on the core failed");
            abort_run();
        end
        if (rst_n && data_wen) begin
            check_value("store address (aligned, inside 1 KB)", data_addr & 32'hffff_fc03, '0);
        end
        if (rst_n && debug_wb_rf_wen != 4'h0) begin
            if (rec_count >= exp_pc.size()) begin
                $display("unexpected register write from pc %h after the last expected one",
                         debug_wb_pc);
                abort_run();
            end else begin
                check_value("writeback pc", debug_wb_pc, exp_pc[rec_count]);
                check_value("writeback register", 32'(debug_wb_rf_wnum),
                            32'(exp_reg[rec_count]));
                check_value("writeback data", debug_wb_rf_wdata, exp_data[rec_count]);
                rec_count++;
            end
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = 20 * (prog_words + exp_pc.size());
        repeat (limit) @(posedge aclk);
        $display("the program did not finish within %0d cycles", limit);
        abort_run();
    end

    initial begin
        int unsigned reset_extra;
        rst_n       = 1'b0;
        reset_extra = $urandom(82328);   // seeds the generator
        reset_extra = $urandom % 3;
        load_program();
        loaded = 1'b1;
        repeat (3 + reset_extra) @(posedge aclk);
        #1 rst_n = 1'b1;
        while (rec_count < exp_pc.size()) begin
            @(posedge aclk);
        end
        repeat (12) @(posedge aclk);   // room for a stray late write
        if (dut_i.props_i.failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tests/program_input.txt */
# i <byte addr> <instruction> and d <byte addr> <data word>, all hex
# e <pc hex> <register decimal> <value hex>, expected writes in program order
i 00 3c011234  # lui   r1, 0x1234
i 04 34215678  # ori   r1, r1, 0x5678   uses ex/mem result
i 08 2402fffd  # addiu r2, r0, -3
i 0c 24030005  # addiu r3, r0, 5
i 10 00432021  # addu  r4, r2, r3       r2 from wb, r3 from ex/mem
i 14 00622823  # subu  r5, r3, r2
i 18 00253024  # and   r6, r1, r5
i 1c 00433825  # or    r7, r2, r3
i 20 00274026  # xor   r8, r1, r7
i 24 0043482a  # slt   r9, r2, r3
i 28 0062502a  # slt   r10, r3, r2
i 2c 24600007  # addiu r0, r3, 7        no record
i 30 240b0040  # addiu r11, r0, 0x40
i 34 8d6c0000  # lw    r12, 0(r11)
i 38 01836821  # addu  r13, r12, r3     load-use stall
i 3c ad6d0004  # sw    r13, 4(r11)
i 40 8d6e0004  # lw    r14, 4(r11)      reads the stored word
i 44 11cd0002  # beq   r14, r13, +2     taken
i 48 240f0111  # addiu r15, r0, 0x111   skipped
i 4c 24100222  # addiu r16, r0, 0x222   skipped
i 50 14630001  # bne   r3, r3, +1       not taken
i 54 24110077  # addiu r17, r0, 0x77
i 58 16200001  # bne   r17, r0, +1      taken
i 5c 24120099  # addiu r18, r0, 0x99    skipped
i 60 10830001  # beq   r4, r3, +1       not taken
i 64 8d730008  # lw    r19, 8(r11)
i 68 0261a026  # xor   r20, r19, r1     load-use stall
i 6c 1000ffff  # beq   r0, r0, -1       spin here
d 40 00001000
d 44 55555555
d 48 cafe0001
e 00 1 12340000
e 04 1 12345678
e 08 2 fffffffd
e 0c 3 00000005
e 10 4 00000002
e 14 5 00000008
e 18 6 00000008
e 1c 7 fffffffd
e 20 8 edcba985
e 24 9 00000001
e 28 10 00000000
e 30 11 00000040
e 34 12 00001000
e 38 13 00001005
e 40 14 00001005
e 54 17 00000077
e 64 19 cafe0001
e 68 20 d8ca5679

/* build.f */
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/mycpu_top.sv
tests/cpu_properties.sv
tests/tb_top.sv

/* Makefile */
all: run

run:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_top -f build.f --Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
		echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module tb_top -f build.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
